/* vlog.f */
+incdir+include
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/memPort.sv
verilog/datapath.sv
verilog/controlUnit.sv
verilog/cpuTop.sv
testbench/tbMemory.sv
testbench/tbCpu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tbCpu
FILELIST = vlog.f
OBJDIR = obj_dir

.PHONY: simulate clean

# The simulator exits non-zero on $fatal, so make fails with it
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* testbench/tbCpu.sv */
// CPU core testbench
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module tbCpu;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int PROG_LEN = 200;
    localparam int SETUP_LEN = 20;
    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 40 + 100;
    localparam logic [31:0] PROG_END = PROG_LEN * 4;
    localparam logic [4:0] SP_REG = 5'd29;
    localparam logic [31:0] SP_INIT = 32'd227;
    localparam logic [31:0] CAUSE_INVALID = 32'd0;
    localparam logic [31:0] CAUSE_OVERFLOW = 32'd1;
    localparam logic [1:0] EV_WRITE = 2'd0;
    localparam logic [1:0] EV_EXC = 2'd1;
    localparam logic [1:0] EV_NONE = 2'd2;

    logic clk;
    logic reset;
    logic memAck;
    logic [`DATA_WIDTH-1:0] memRdata;
    logic memReq;
    logic [`DATA_WIDTH-1:0] memAddr;
    logic wbValid;
    logic [`REG_ADDR_WIDTH-1:0] wbReg;
    logic [`DATA_WIDTH-1:0] wbData;
    logic excValid;
    excCauseT excCause;
    logic [`DATA_WIDTH-1:0] excPc;

    integer seed;
    int cycleCount;
    logic [31:0] progWords [PROG_LEN];
    logic [31:0] modelRegs [32];
    logic [1:0] expKind [$];
    logic [31:0] expIndex [$];
    logic [31:0] expValue [$];
    logic [1:0] curKind;
    logic [31:0] curIndex;
    logic [31:0] curValue;

    cpuTop u_cpuTop (
        .clk(clk),
        .reset(reset),
        .memAck(memAck),
        .memRdata(memRdata),
        .memReq(memReq),
        .memAddr(memAddr),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData),
        .excValid(excValid),
        .excCause(excCause),
        .excPc(excPc)
    );

    tbMemory u_memory (
        .clk(clk),
        .reset(reset),
        .memReq(memReq),
        .memAddr(memAddr),
        .memAck(memAck),
        .memRdata(memRdata)
    );

    always #50 clk = ~clk;

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation aborted");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
            input string what);
        if (actual !== expected) begin
            stopWithFailure($sformatf("Mismatch at %0t: %s is 0x%08h, expected 0x%08h",
                $time, what, actual, expected));
        end
    endtask

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
            input logic [4:0] rd, input logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Reference model, one instruction; returns the event kind
    function automatic logic [1:0] modelInstr(input logic [31:0] word, input logic [31:0] pc,
            output logic [31:0] index, output logic [31:0] value);
        logic [5:0] op;
        logic [5:0] funct;
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] wide;
        logic [4:0] dest;
        logic valid;
        logic trap;
        op = word[31:26];
        funct = word[5:0];
        a = modelRegs[word[25:21]];
        b = modelRegs[word[20:16]];
        dest = word[20:16];
        valid = 1'b1;
        trap = 1'b0;
        wide = '0;
        index = '0;
        value = '0;
        if (op == OP_RTYPE && (funct == FUNCT_ADD || funct == FUNCT_SUB)) begin
            dest = word[15:11];
            if (funct == FUNCT_SUB) begin
                wide = {a[31], a} - {b[31], b};
            end else begin
                wide = {a[31], a} + {b[31], b};
            end
            trap = wide[32] != wide[31];
        end else if (op == OP_ADDI) begin
            b = {{16{word[15]}}, word[15:0]};
            wide = {a[31], a} + {b[31], b};
            trap = wide[32] != wide[31];
        end else if (op == OP_ADDIU) begin
            b = {16'h0000, word[15:0]};
            wide = {a[31], a} + {b[31], b};
        end else begin
            valid = 1'b0;
        end
        if (!valid) begin
            index = CAUSE_INVALID;
            value = pc;
            return EV_EXC;
        end
        if (trap) begin
            index = CAUSE_OVERFLOW;
            value = pc;
            return EV_EXC;
        end
        if (dest == 5'd0) begin
            return EV_NONE;
        end
        modelRegs[dest] = wide[31:0];
        index = 32'(dest);
        value = wide[31:0];
        return EV_WRITE;
    endfunction

    task automatic buildProgram();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [5:0] code;
        // r8 ends at 0x7ffffffe and r9 at 0x80000000
        progWords[0] = encodeI(OP_ADDIU, 5'd0, 5'd8, 16'h7fff);
        for (int i = 1; i <= 16; i++) begin
            progWords[i] = encodeR(5'd8, 5'd8, 5'd8, FUNCT_ADD);
        end
        progWords[17] = encodeI(OP_ADDIU, 5'd8, 5'd8, 16'hfffe);
        progWords[18] = encodeR(5'd0, 5'd8, 5'd9, FUNCT_SUB);
        progWords[19] = encodeI(OP_ADDI, 5'd9, 5'd9, 16'hfffe);
        for (int i = SETUP_LEN; i < PROG_LEN; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            rs = r[4:0];
            rt = r[9:5];
            rd = r[14:10];
            // Pull in the near-limit operands now and then
            if (r[16:15] == 2'b00) begin
                rs = {4'b0100, r[17]};
            end
            if (r[19:18] == 2'b00) begin
                rt = {4'b0100, r[20]};
            end
            if (rd[4:1] == 4'b0100) begin
                rd = 5'd0;
            end
            code = r2[9:4];
            case (r2[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: progWords[i] = encodeR(rs, rt, rd, FUNCT_ADD);
                4'd4, 4'd5, 4'd6, 4'd7: progWords[i] = encodeR(rs, rt, rd, FUNCT_SUB);
                4'd8, 4'd9, 4'd10, 4'd11, 4'd12, 4'd13: begin
                    if (rt[4:1] == 4'b0100) begin
                        rt = 5'd0;
                    end
                    progWords[i] = encodeI(r2[3:0] < 4'd11 ? OP_ADDI : OP_ADDIU, rs, rt,
                        r2[31:16]);
                end
                4'd14: begin
                    if (code == OP_RTYPE || code == OP_ADDI || code == OP_ADDIU) begin
                        code = 6'h3f;
                    end
                    progWords[i] = encodeI(code, rs, rt, r2[31:16]);
                end
                default: begin
                    if (code == FUNCT_ADD || code == FUNCT_SUB) begin
                        code = 6'h3f;
                    end
                    progWords[i] = encodeR(rs, rt, rd, code);
                end
            endcase
        end
    endtask

    task automatic buildExpected();
        logic [1:0] kind;
        logic [31:0] index;
        logic [31:0] value;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        // Reset state loads the stack pointer
        modelRegs[SP_REG] = SP_INIT;
        expKind.push_back(EV_WRITE);
        expIndex.push_back(32'(SP_REG));
        expValue.push_back(SP_INIT);
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = modelInstr(progWords[i], 32'(i * 4), index, value);
            if (kind != EV_NONE) begin
                expKind.push_back(kind);
                expIndex.push_back(index);
                expValue.push_back(value);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cycleCount = 0;
        seed = 32'hd8f48af8;
        buildProgram();
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < PROG_LEN) begin
                u_memory.words[i] = progWords[i];
            end else begin
                u_memory.words[i] = {6'h3f, 26'(i)};
            end
        end
        buildExpected();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    // Trace events against the reference, mid-cycle
    always @(negedge clk) begin
        if (!reset && (wbValid || excValid)) begin
            if (expKind.size() == 0) begin
                stopWithFailure("DUT reported an event after the last expected one");
            end else begin
                curKind = expKind.pop_front();
                curIndex = expIndex.pop_front();
                curValue = expValue.pop_front();
                if (wbValid) begin
                    checkValue(32'(EV_WRITE), 32'(curKind), "event kind, 0 write 1 exception");
                    checkValue(32'(wbReg), curIndex, "write register");
                    checkValue(wbData, curValue, "write data");
                end else begin
                    checkValue(32'(EV_EXC), 32'(curKind), "event kind, 0 write 1 exception");
                    checkValue(32'(excCause), curIndex, "exception cause");
                    checkValue(excPc, curValue, "exception PC");
                end
            end
        end
    end

    // Fetch past the last instruction ends the run
    always @(negedge clk) begin
        if (!reset && memReq && memAddr == PROG_END) begin
            if (expKind.size() == 0) begin
                $display("Test passed");
                $finish;
            end else begin
                stopWithFailure($sformatf("Program ended with %0d expected events not seen",
                    expKind.size()));
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TIMEOUT_CYCLES) begin
            stopWithFailure($sformatf("Timeout, program not finished after %0d cycles",
                TIMEOUT_CYCLES));
        end
    end

endmodule

`default_nettype wire

/* testbench/tbMemory.sv */
// Instruction memory model
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module tbMemory #(
    parameter int ADDR_BITS = 8
) (
    input wire clk,
    input wire reset,
    input wire memReq,
    input wire [`DATA_WIDTH-1:0] memAddr,
    output logic memAck,
    output logic [`DATA_WIDTH-1:0] memRdata
);

    localparam int DEPTH = 1 << ADDR_BITS;

    // Loaded by the testbench top before reset ends
    logic [`DATA_WIDTH-1:0] words [DEPTH];
    integer seed;

    // Stall 0 to 3 cycles, ending just past a rising edge
    task automatic randomStall();
        logic [31:0] r;
        int count;
        r = $random(seed);
        count = int'(r[1:0]);
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        seed = 32'hd8f48af8;
        memAck = 1'b0;
        memRdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && memReq) begin
                randomStall();
                memRdata = words[memAddr[ADDR_BITS+1:2]];
                memAck = 1'b1;
                // Hold ack until the master lets go of req
                while (memReq) begin
                    @(posedge clk);
                    #1;
                end
                randomStall();
                memAck = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cpuTop.sv */
// Core top level
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpuTop (
    input wire clk,
    input wire reset,
    input wire memAck,
    input wire [`DATA_WIDTH-1:0] memRdata,
    output logic memReq,
    output logic [`DATA_WIDTH-1:0] memAddr,
    output logic wbValid,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg,
    output logic [`DATA_WIDTH-1:0] wbData,
    output logic excValid,
    output ctrlPkg::excCauseT excCause,
    output logic [`DATA_WIDTH-1:0] excPc
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic fetchStart;
    logic fetchDone;
    logic [`DATA_WIDTH-1:0] fetchData;
    logic [`DATA_WIDTH-1:0] pc;
    instrT instr;
    logic overflow;
    logic pcWrite;
    logic irWrite;
    logic loadAB;
    logic aluOutLoad;
    logic epcWrite;
    logic regWrite;
    srcASelT srcASel;
    srcBSelT srcBSel;
    aluOpT aluOp;
    wrRegSelT wrRegSel;
    wrDataSelT wrDataSel;

    memPort u_memPort (
        .clk(clk),
        .reset(reset),
        .fetchStart(fetchStart),
        .pc(pc),
        .memAck(memAck),
        .memRdata(memRdata),
        .memReq(memReq),
        .memAddr(memAddr),
        .fetchDone(fetchDone),
        .fetchData(fetchData)
    );

    datapath u_datapath (
        .clk(clk),
        .reset(reset),
        .pcWrite(pcWrite),
        .irWrite(irWrite),
        .loadAB(loadAB),
        .aluOutLoad(aluOutLoad),
        .epcWrite(epcWrite),
        .regWrite(regWrite),
        .srcASel(srcASel),
        .srcBSel(srcBSel),
        .aluOp(aluOp),
        .wrRegSel(wrRegSel),
        .wrDataSel(wrDataSel),
        .fetchData(fetchData),
        .pc(pc),
        .instr(instr),
        .overflow(overflow),
        .wbReg(wbReg),
        .wbData(wbData),
        .excPc(excPc)
    );

    controlUnit u_controlUnit (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .overflow(overflow),
        .fetchDone(fetchDone),
        .fetchStart(fetchStart),
        .pcWrite(pcWrite),
        .irWrite(irWrite),
        .loadAB(loadAB),
        .aluOutLoad(aluOutLoad),
        .epcWrite(epcWrite),
        .regWrite(regWrite),
        .srcASel(srcASel),
        .srcBSel(srcBSel),
        .aluOp(aluOp),
        .wrRegSel(wrRegSel),
        .wrDataSel(wrDataSel),
        .wbValid(wbValid),
        .excValid(excValid),
        .excCause(excCause)
    );

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
// Multicycle control FSM
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module controlUnit (
    input wire clk,
    input wire reset,
    input wire isaPkg::instrT instr,
    input wire overflow,
    input wire fetchDone,
    output logic fetchStart,
    output logic pcWrite,
    output logic irWrite,
    output logic loadAB,
    output logic aluOutLoad,
    output logic epcWrite,
    output logic regWrite,
    output ctrlPkg::srcASelT srcASel,
    output ctrlPkg::srcBSelT srcBSel,
    output ctrlPkg::aluOpT aluOp,
    output ctrlPkg::wrRegSelT wrRegSel,
    output ctrlPkg::wrDataSelT wrDataSel,
    output logic wbValid,
    output logic excValid,
    output ctrlPkg::excCauseT excCause
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    excCauseT nextCause;
    srcBSelT execSrcB;
    logic isRType;
    logic validOp;
    logic trapOp;
    logic [`REG_ADDR_WIDTH-1:0] destReg;

    // Instruction decode
    always_comb begin
        isRType = (instr.r.opcode == OP_RTYPE);
        validOp = 1'b0;
        trapOp = 1'b1;
        execSrcB = SRC_B_REG;
        case (instr.r.opcode)
            OP_RTYPE: begin
                validOp = (instr.r.funct == FUNCT_ADD) || (instr.r.funct == FUNCT_SUB);
            end
            OP_ADDI: begin
                validOp = 1'b1;
                execSrcB = SRC_B_SIGN_IMM;
            end
            OP_ADDIU: begin
                validOp = 1'b1;
                trapOp = 1'b0;
                execSrcB = SRC_B_ZERO_IMM;
            end
            default: validOp = 1'b0;
        endcase
        destReg = isRType ? instr.r.rd : instr.i.rt;
    end

    always_comb begin
        nextState = state;
        nextCause = EXC_INVALID;
        case (state)
            ST_RESET: begin
                // Stay until the stack pointer write went out
                if (wbValid) begin
                    nextState = ST_FETCH;
                end
            end
            ST_FETCH: begin
                if (fetchDone) begin
                    nextState = ST_DECODE;
                end
            end
            ST_DECODE: nextState = ST_DECODE2;
            ST_DECODE2: nextState = validOp ? ST_EXECUTE : ST_EXCEPTION;
            ST_EXECUTE: begin
                if (overflow && trapOp) begin
                    nextState = ST_EXCEPTION;
                    nextCause = EXC_OVERFLOW;
                end else begin
                    nextState = ST_WRITEBACK;
                end
            end
            ST_WRITEBACK: nextState = ST_FETCH;
            ST_EXCEPTION: nextState = ST_FETCH;
            default: nextState = ST_RESET;
        endcase
    end

    // Controls are registered for the state being entered
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
            fetchStart <= 1'b0;
            pcWrite <= 1'b0;
            irWrite <= 1'b0;
            loadAB <= 1'b0;
            aluOutLoad <= 1'b0;
            epcWrite <= 1'b0;
            regWrite <= 1'b0;
            srcASel <= SRC_A_PC;
            srcBSel <= SRC_B_FOUR;
            aluOp <= ALU_ADD;
            wrRegSel <= WR_REG_RD;
            wrDataSel <= WR_DATA_ALU_OUT;
            wbValid <= 1'b0;
            excValid <= 1'b0;
            excCause <= EXC_INVALID;
        end else begin
            state <= nextState;
            fetchStart <= 1'b0;
            pcWrite <= 1'b0;
            irWrite <= 1'b0;
            loadAB <= 1'b0;
            aluOutLoad <= 1'b0;
            epcWrite <= 1'b0;
            regWrite <= 1'b0;
            wbValid <= 1'b0;
            excValid <= 1'b0;
            case (nextState)
                ST_RESET: begin
                    regWrite <= 1'b1;
                    wbValid <= 1'b1;
                    wrRegSel <= WR_REG_STACK;
                    wrDataSel <= WR_DATA_STACK_TOP;
                end
                ST_FETCH: fetchStart <= (state != ST_FETCH);
                ST_DECODE: begin
                    // PC + 4 while IR loads
                    pcWrite <= 1'b1;
                    irWrite <= 1'b1;
                    srcASel <= SRC_A_PC;
                    srcBSel <= SRC_B_FOUR;
                    aluOp <= ALU_ADD;
                end
                ST_DECODE2: loadAB <= 1'b1;
                ST_EXECUTE: begin
                    aluOutLoad <= 1'b1;
                    srcASel <= SRC_A_REG;
                    srcBSel <= execSrcB;
                    aluOp <= (isRType && instr.r.funct == FUNCT_SUB) ? ALU_SUB : ALU_ADD;
                end
                ST_WRITEBACK: begin
                    regWrite <= (destReg != '0);
                    wbValid <= (destReg != '0);
                    wrRegSel <= isRType ? WR_REG_RD : WR_REG_RT;
                    wrDataSel <= WR_DATA_ALU_OUT;
                end
                default: begin
                    // Faulting address is PC - 4
                    epcWrite <= 1'b1;
                    excValid <= 1'b1;
                    excCause <= nextCause;
                    srcASel <= SRC_A_PC;
                    srcBSel <= SRC_B_FOUR;
                    aluOp <= ALU_SUB;
                end
            endcase
        end
    end

    writeOrTrap: assert property (@(posedge clk) disable iff (reset)
        !(regWrite && epcWrite))
        else $error("Register write during exception");

endmodule

`default_nettype wire

/* verilog/datapath.sv */
// Multicycle datapath
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module datapath (
    input wire clk,
    input wire reset,
    input wire pcWrite,
    input wire irWrite,
    input wire loadAB,
    input wire aluOutLoad,
    input wire epcWrite,
    input wire regWrite,
    input wire ctrlPkg::srcASelT srcASel,
    input wire ctrlPkg::srcBSelT srcBSel,
    input wire ctrlPkg::aluOpT aluOp,
    input wire ctrlPkg::wrRegSelT wrRegSel,
    input wire ctrlPkg::wrDataSelT wrDataSel,
    input wire [`DATA_WIDTH-1:0] fetchData,
    output logic [`DATA_WIDTH-1:0] pc,
    output isaPkg::instrT instr,
    output logic overflow,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg,
    output logic [`DATA_WIDTH-1:0] wbData,
    output logic [`DATA_WIDTH-1:0] excPc
);
    import ctrlPkg::*;

    localparam logic [`DATA_WIDTH-1:0] WORD_BYTES = 4;

    logic [`DATA_WIDTH-1:0] aReg;
    logic [`DATA_WIDTH-1:0] bReg;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic [`DATA_WIDTH-1:0] epc;
    logic [`DATA_WIDTH-1:0] rsData;
    logic [`DATA_WIDTH-1:0] rtData;
    logic [`DATA_WIDTH-1:0] signImm;
    logic [`DATA_WIDTH-1:0] zeroImm;
    logic [`DATA_WIDTH-1:0] aluA;
    logic [`DATA_WIDTH-1:0] aluB;
    logic [`DATA_WIDTH-1:0] aluResult;

    always_comb begin
        signImm = {{(`DATA_WIDTH-16){instr.i.imm[15]}}, instr.i.imm};
        zeroImm = {{(`DATA_WIDTH-16){1'b0}}, instr.i.imm};
        aluA = (srcASel == SRC_A_PC) ? pc : aReg;
        case (srcBSel)
            SRC_B_FOUR: aluB = WORD_BYTES;
            SRC_B_REG: aluB = bReg;
            SRC_B_SIGN_IMM: aluB = signImm;
            default: aluB = zeroImm;
        endcase
        case (wrRegSel)
            WR_REG_RD: wbReg = instr.r.rd;
            WR_REG_RT: wbReg = instr.i.rt;
            default: wbReg = `STACK_REG;
        endcase
        wbData = (wrDataSel == WR_DATA_STACK_TOP) ? `STACK_TOP : aluOut;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (pcWrite) begin
            pc <= aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) begin
            instr <= fetchData;
        end
        if (loadAB) begin
            aReg <= rsData;
            bReg <= rtData;
        end
        if (aluOutLoad) begin
            aluOut <= aluResult;
        end
        // PC minus four, computed in the exception state
        if (epcWrite) begin
            epc <= aluResult;
        end
    end

    // Trace shows EPC in the cycle it is written
    assign excPc = epcWrite ? aluResult : epc;

    regFile u_regFile (
        .clk(clk),
        .reset(reset),
        .rsAddr(instr.r.rs),
        .rtAddr(instr.r.rt),
        .wrAddr(wbReg),
        .wrData(wbData),
        .wrEnable(regWrite),
        .rsData(rsData),
        .rtData(rtData)
    );

    alu u_alu (
        .a(aluA),
        .b(aluB),
        .aluOp(aluOp),
        .result(aluResult),
        .overflow(overflow)
    );

endmodule

`default_nettype wire

/* verilog/memPort.sv */
// Four-phase instruction read master
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module memPort (
    input wire clk,
    input wire reset,
    input wire fetchStart,
    input wire [`DATA_WIDTH-1:0] pc,
    input wire memAck,
    input wire [`DATA_WIDTH-1:0] memRdata,
    output logic memReq,
    output logic [`DATA_WIDTH-1:0] memAddr,
    output logic fetchDone,
    output logic [`DATA_WIDTH-1:0] fetchData
);

    typedef enum logic [1:0] {PH_IDLE, PH_REQUEST, PH_RELEASE} phaseT;

    phaseT phase;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PH_IDLE;
            memReq <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (fetchStart) begin
                        memReq <= 1'b1;
                        phase <= PH_REQUEST;
                    end
                end
                PH_REQUEST: begin
                    if (memAck) begin
                        memReq <= 1'b0;
                        phase <= PH_RELEASE;
                    end
                end
                default: begin
                    // Done only once the slave lets go of ack
                    if (!memAck) begin
                        fetchDone <= 1'b1;
                        phase <= PH_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && fetchStart) begin
            memAddr <= pc;
        end
        if (phase == PH_REQUEST && memAck) begin
            fetchData <= memRdata;
        end
    end

    reqAfterAckLow: assert property (@(posedge clk) disable iff (reset)
        memAck && !memReq |=> !memReq)
        else $error("memReq rose while memAck high");

    addrStable: assert property (@(posedge clk) disable iff (reset)
        memReq |=> !memReq || $stable(memAddr))
        else $error("memAddr changed during request");

endmodule

`default_nettype wire

/* verilog/regFile.sv */
// General register file
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module regFile (
    input wire clk,
    input wire reset,
    input wire [`REG_ADDR_WIDTH-1:0] rsAddr,
    input wire [`REG_ADDR_WIDTH-1:0] rtAddr,
    input wire [`REG_ADDR_WIDTH-1:0] wrAddr,
    input wire [`DATA_WIDTH-1:0] wrData,
    input wire wrEnable,
    output logic [`DATA_WIDTH-1:0] rsData,
    output logic [`DATA_WIDTH-1:0] rtData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEnable) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Register zero is hardwired
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    // Control unit filters writes to register zero
    noZeroWrite: assert property (@(posedge clk) disable iff (reset)
        wrEnable |-> wrAddr != '0)
        else $error("Write to register zero");

endmodule

`default_nettype wire

/* verilog/alu.sv */
// Adder and subtractor
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module alu (
    input wire [`DATA_WIDTH-1:0] a,
    input wire [`DATA_WIDTH-1:0] b,
    input wire ctrlPkg::aluOpT aluOp,
    output logic [`DATA_WIDTH-1:0] result,
    output logic overflow
);
    import ctrlPkg::*;

    localparam int MSB = `DATA_WIDTH - 1;

    logic [`DATA_WIDTH-1:0] bOperand;
    logic carryIn;

    always_comb begin
        // Subtract as a plus inverted b plus one
        carryIn = (aluOp == ALU_SUB);
        bOperand = carryIn ? ~b : b;
        result = a + bOperand + {{(`DATA_WIDTH-1){1'b0}}, carryIn};

        // Operands agree in sign but the result does not
        overflow = (a[MSB] == bOperand[MSB]) && (result[MSB] != a[MSB]);
    end

endmodule

`default_nettype wire

/* verilog/ctrlPkg.sv */
// Control unit types
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_FETCH,
        ST_DECODE,
        ST_DECODE2,
        ST_EXECUTE,
        ST_WRITEBACK,
        ST_EXCEPTION
    } ctrlStateT;

    typedef enum logic {ALU_ADD, ALU_SUB} aluOpT;

    typedef enum logic {SRC_A_PC, SRC_A_REG} srcASelT;

    typedef enum logic [1:0] {
        SRC_B_FOUR,
        SRC_B_REG,
        SRC_B_SIGN_IMM,
        SRC_B_ZERO_IMM
    } srcBSelT;

    typedef enum logic [1:0] {WR_REG_RD, WR_REG_RT, WR_REG_STACK} wrRegSelT;

    typedef enum logic {WR_DATA_ALU_OUT, WR_DATA_STACK_TOP} wrDataSelT;

    typedef enum logic {EXC_INVALID = 1'b0, EXC_OVERFLOW = 1'b1} excCauseT;

endpackage

`default_nettype wire

/* verilog/isaPkg.sv */
// Instruction set encodings
`default_nettype none

package isaPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    localparam opcodeT OP_RTYPE = 6'b000000;
    localparam opcodeT OP_ADDI = 6'b001000;
    localparam opcodeT OP_ADDIU = 6'b001001;

    localparam functT FUNCT_ADD = 6'b100000;
    localparam functT FUNCT_SUB = 6'b100010;

    typedef struct packed {
        opcodeT opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functT funct;
    } rInstrT;

    typedef struct packed {
        opcodeT opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] imm;
    } iInstrT;

    // Same word, register or immediate format
    typedef union packed {
        rInstrT r;
        iInstrT i;
    } instrT;

endpackage

`default_nettype wire

/* include/cpu_params.svh */
// CPU configuration constants
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and register file sizes
`define DATA_WIDTH 32
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// First fetch address
`define RESET_PC 32'h0000_0000

// Stack pointer setup done by the reset state
`define STACK_REG 5'd29
`define STACK_TOP 32'd227

`endif
